/* logic/llink_config.svh */
`ifndef LLINK_CONFIG_SVH
`define LLINK_CONFIG_SVH

////////////////////
// Channel layout
////////////////////

// Number of user channels over one PHY word
`define LLINK_CHAN_COUNT 4
// Payload bits per user channel
`define LLINK_CHAN_W 74

////////////////////
// PHY word layout
////////////////////

// One group per channel
`define LLINK_GROUP_W 80
// Four groups side by side
`define LLINK_PHY_W 320
// Marker user bits, one per group
`define LLINK_MRK_W 4
// Bit positions inside a group
`define LLINK_MRK_BIT 74
`define LLINK_STB_BIT 75

////////////////////
// Control and debug
////////////////////

// Online delay counters
`define LLINK_DELAY_W 16
// Sync state code width
`define LLINK_SYNC_W 2
// Debug word and its level bits
`define LLINK_DEBUG_W 32
`define LLINK_DBG_TX_BIT 19
`define LLINK_DBG_RX_BIT 18

`endif

/* logic/llink_data_pkg.sv */
`include "llink_config.svh"

// Data path types shared by unpack, slots and pack
package llink_data_pkg;

  // One user channel word
  typedef logic [`LLINK_CHAN_W-1:0] chan_data_t;

  // One group of the PHY word
  // Data in the low bits, marker and strobe above
  typedef logic [`LLINK_GROUP_W-1:0] group_t;

  // Full PHY word, group 0 in the low bits
  typedef logic [`LLINK_PHY_W-1:0] phy_word_t;

  // Marker user bits, bit g goes to group g
  typedef logic [`LLINK_MRK_W-1:0] mrk_bits_t;

endpackage

/* logic/llink_ctrl_pkg.sv */
`include "llink_config.svh"

// Control side types for the online delay logic
package llink_ctrl_pkg;

  // Programmable online delay count
  typedef logic [`LLINK_DELAY_W-1:0] delay_t;

  // Delay machine states
  // Code goes out on the low bits of the debug word
  typedef enum logic [`LLINK_SYNC_W-1:0] {
    SYNC_OFF     = 2'd0,
    SYNC_TX_WAIT = 2'd1,
    SYNC_RX_WAIT = 2'd2,
    SYNC_UP      = 2'd3
  } sync_state_t;

  // Debug status word
  typedef logic [`LLINK_DEBUG_W-1:0] debug_status_t;

endpackage

/* logic/llink_lane_if.sv */
`timescale 1ns/1ps

// One lane between PHY unpack, channel slot and PHY pack
interface llink_lane_if ();

  // Receive data field sliced out of the PHY word
  llink_data_pkg::chan_data_t rx_field;
  // Delayed online levels, copied per lane
  logic                       rx_en;
  logic                       tx_en;
  // Transmit data field headed for the PHY word
  llink_data_pkg::chan_data_t tx_field;

  // Unpack side drives the receive field and both enables
  modport unpack_mp (
    output rx_field,
    output rx_en,
    output tx_en
  );

  // Slot consumes receive side, produces transmit field
  modport slot_mp (
    input  rx_field,
    input  rx_en,
    input  tx_en,
    output tx_field
  );

  // Pack only reads the transmit field
  modport pack_mp (
    input tx_field
  );

endinterface

/* logic/llink_auto_sync.sv */
`timescale 1ns/1ps

module llink_auto_sync (
  input  logic                       clk_wr,
  input  logic                       arst_n,

  // Raw online levels
  input  logic                       tx_online,
  input  logic                       rx_online,

  // Programmable delays
  input  llink_ctrl_pkg::delay_t     delay_x_value,
  input  llink_ctrl_pkg::delay_t     delay_y_value,

  // User bits before gating
  input  llink_data_pkg::mrk_bits_t  tx_mrk_userbit,
  input  logic                       tx_stb_userbit,

  // Delayed online levels
  output logic                       tx_online_delay,
  output logic                       rx_online_delay,

  // Gated user bits for pack
  output llink_data_pkg::mrk_bits_t  tx_auto_mrk_userbit,
  output logic                       tx_auto_stb_userbit,

  output llink_ctrl_pkg::sync_state_t sync_state
);

  llink_ctrl_pkg::sync_state_t state_q, state_d;
  llink_ctrl_pkg::delay_t      cnt_q, cnt_d;
  // Set once rx side has seen both levels high
  logic                        rx_arm_q, rx_arm_d;

  ////////////////////
  // Delay machine
  ////////////////////

  always_comb begin
    state_d  = state_q;
    cnt_d    = cnt_q;
    rx_arm_d = rx_arm_q;
    // Losing tx drops everything on the next edge
    if (!tx_online) begin
      state_d  = llink_ctrl_pkg::SYNC_OFF;
      rx_arm_d = 1'b0;
    end else begin
      case (state_q)
        llink_ctrl_pkg::SYNC_OFF: begin
          // First high sample, start the tx count
          state_d = llink_ctrl_pkg::SYNC_TX_WAIT;
          cnt_d   = delay_x_value;
        end
        llink_ctrl_pkg::SYNC_TX_WAIT: begin
          if (cnt_q == '0) begin
            state_d  = llink_ctrl_pkg::SYNC_RX_WAIT;
            rx_arm_d = 1'b0;
          end else begin
            cnt_d = cnt_q - llink_ctrl_pkg::delay_t'(1);
          end
        end
        llink_ctrl_pkg::SYNC_RX_WAIT: begin
          if (!rx_online) begin
            rx_arm_d = 1'b0;
          end else if (!rx_arm_q) begin
            // First cycle with both high, load rx count
            rx_arm_d = 1'b1;
            cnt_d    = delay_y_value;
          end else if (cnt_q == '0) begin
            state_d = llink_ctrl_pkg::SYNC_UP;
          end else begin
            cnt_d = cnt_q - llink_ctrl_pkg::delay_t'(1);
          end
        end
        llink_ctrl_pkg::SYNC_UP: begin
          // Rx drop falls back, tx stays up
          if (!rx_online) begin
            state_d  = llink_ctrl_pkg::SYNC_RX_WAIT;
            rx_arm_d = 1'b0;
          end
        end
        default: state_d = llink_ctrl_pkg::SYNC_OFF;
      endcase
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      state_q  <= llink_ctrl_pkg::SYNC_OFF;
      cnt_q    <= '0;
      rx_arm_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      cnt_q    <= cnt_d;
      rx_arm_q <= rx_arm_d;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  // Levels straight from the state register
  assign tx_online_delay = (state_q == llink_ctrl_pkg::SYNC_RX_WAIT) ||
                           (state_q == llink_ctrl_pkg::SYNC_UP);
  assign rx_online_delay = (state_q == llink_ctrl_pkg::SYNC_UP);
  assign sync_state      = state_q;

  // Persistent marker and strobe, held while tx is up
  assign tx_auto_mrk_userbit = tx_online_delay ? tx_mrk_userbit : '0;
  assign tx_auto_stb_userbit = tx_online_delay & tx_stb_userbit;

endmodule

/* logic/llink_phy_unpack.sv */
`timescale 1ns/1ps
`include "llink_config.svh"

module llink_phy_unpack (
  input  logic                      clk_wr,
  input  logic                      arst_n,

  // Received PHY word
  input  llink_data_pkg::phy_word_t rx_phy0,

  // Delayed online levels from auto sync
  input  logic                      tx_online_delay,
  input  logic                      rx_online_delay,

  // One lane per channel
  llink_lane_if.unpack_mp           lanes [`LLINK_CHAN_COUNT]
);

  llink_data_pkg::phy_word_t rx_phy_q;

  ////////////////////
  // Input register
  ////////////////////

  // First of the two receive stages
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_phy_q <= '0;
    end else begin
      rx_phy_q <= rx_phy0;
    end
  end

  ////////////////////
  // Lane slicing
  ////////////////////

  for (genvar g = 0; g < `LLINK_CHAN_COUNT; g++) begin : g_lane
    llink_data_pkg::group_t rx_grp;

    // Group g sits at bit 80*g
    assign rx_grp = rx_phy_q[g*`LLINK_GROUP_W +: `LLINK_GROUP_W];

    // Data bits only
    // Marker and strobe in the received group are dropped here
    assign lanes[g].rx_field = rx_grp[`LLINK_CHAN_W-1:0];

    // Every lane follows the same online levels
    assign lanes[g].rx_en = rx_online_delay;
    assign lanes[g].tx_en = tx_online_delay;
  end

endmodule

/* logic/llink_chan_slot.sv */
`timescale 1ns/1ps

module llink_chan_slot (
  input  logic                       clk_wr,
  input  logic                       arst_n,

  // Lane to unpack and pack
  llink_lane_if.slot_mp              lane,

  // User side of the channel
  input  llink_data_pkg::chan_data_t user_rx_data,
  output llink_data_pkg::chan_data_t user_tx_data
);

  llink_data_pkg::chan_data_t tx_field_q;

  ////////////////////
  // Receive direction
  ////////////////////

  // Second receive stage, forced to zero while rx is offline
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      user_tx_data <= '0;
    end else if (lane.rx_en) begin
      user_tx_data <= lane.rx_field;
    end else begin
      user_tx_data <= '0;
    end
  end

  ////////////////////
  // Transmit direction
  ////////////////////

  // First transmit stage, zero until tx is online
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_field_q <= '0;
    end else if (lane.tx_en) begin
      tx_field_q <= user_rx_data;
    end else begin
      tx_field_q <= '0;
    end
  end

  // Handed to pack
  assign lane.tx_field = tx_field_q;

endmodule

/* logic/llink_phy_pack.sv */
`timescale 1ns/1ps
`include "llink_config.svh"

module llink_phy_pack (
  input  logic                      clk_wr,
  input  logic                      arst_n,

  // Transmit fields from the slots
  llink_lane_if.pack_mp             lanes [`LLINK_CHAN_COUNT],

  // Gated user bits from auto sync
  input  llink_data_pkg::mrk_bits_t mrk_userbit,
  input  logic                      stb_userbit,

  // Transmitted PHY word
  output llink_data_pkg::phy_word_t tx_phy0
);

  llink_data_pkg::phy_word_t phy_next;

  ////////////////////
  // Group assembly
  ////////////////////

  for (genvar g = 0; g < `LLINK_CHAN_COUNT; g++) begin : g_grp
    llink_data_pkg::group_t tx_grp;

    always_comb begin
      // Upper pad bits stay zero
      tx_grp = '0;
      tx_grp[`LLINK_CHAN_W-1:0] = lanes[g].tx_field;
      tx_grp[`LLINK_MRK_BIT]    = mrk_userbit[g];
      // Strobe rides in group 0 only
      tx_grp[`LLINK_STB_BIT]    = (g == 0) ? stb_userbit : 1'b0;
    end

    assign phy_next[g*`LLINK_GROUP_W +: `LLINK_GROUP_W] = tx_grp;
  end

  ////////////////////
  // Output register
  ////////////////////

  // Last transmit stage
  // User bits see only this one
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= phy_next;
    end
  end

endmodule

/* logic/llink_fourchan_top.sv */
`timescale 1ns/1ps
`include "llink_config.svh"

module llink_fourchan_top (
  input  logic                          clk_wr,
  input  logic                          arst_n,

  // Online control
  input  logic                          tx_online,
  input  logic                          rx_online,
  input  llink_ctrl_pkg::delay_t        delay_x_value,
  input  llink_ctrl_pkg::delay_t        delay_y_value,

  // Transmit user bits
  input  llink_data_pkg::mrk_bits_t     tx_mrk_userbit,
  input  logic                          tx_stb_userbit,

  // PHY side
  input  llink_data_pkg::phy_word_t     rx_phy0,
  output llink_data_pkg::phy_word_t     tx_phy0,

  // User channels into the link
  input  llink_data_pkg::chan_data_t    ch0_rx_data,
  input  llink_data_pkg::chan_data_t    ch1_rx_data,
  input  llink_data_pkg::chan_data_t    ch2_rx_data,
  input  llink_data_pkg::chan_data_t    ch3_rx_data,

  // User channels out of the link
  output llink_data_pkg::chan_data_t    ch0_tx_data,
  output llink_data_pkg::chan_data_t    ch1_tx_data,
  output llink_data_pkg::chan_data_t    ch2_tx_data,
  output llink_data_pkg::chan_data_t    ch3_tx_data,

  output llink_ctrl_pkg::debug_status_t debug_status
);

  logic                        tx_online_delay;
  logic                        rx_online_delay;
  llink_data_pkg::mrk_bits_t   tx_auto_mrk_userbit;
  logic                        tx_auto_stb_userbit;
  llink_ctrl_pkg::sync_state_t sync_state;

  // Per channel user data, indexed for the slot loop
  llink_data_pkg::chan_data_t  user_rx [`LLINK_CHAN_COUNT];
  llink_data_pkg::chan_data_t  user_tx [`LLINK_CHAN_COUNT];

  llink_lane_if lane_bus [`LLINK_CHAN_COUNT] ();

  assign user_rx[0]  = ch0_rx_data;
  assign user_rx[1]  = ch1_rx_data;
  assign user_rx[2]  = ch2_rx_data;
  assign user_rx[3]  = ch3_rx_data;
  assign ch0_tx_data = user_tx[0];
  assign ch1_tx_data = user_tx[1];
  assign ch2_tx_data = user_tx[2];
  assign ch3_tx_data = user_tx[3];

  ////////////////////
  // Auto sync
  ////////////////////

  llink_auto_sync i_auto_sync (
    .clk_wr              (clk_wr),
    .arst_n              (arst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .sync_state          (sync_state)
  );

  // Debug word, both levels plus state code
  always_comb begin
    debug_status = '0;
    debug_status[`LLINK_DBG_TX_BIT]   = tx_online_delay;
    debug_status[`LLINK_DBG_RX_BIT]   = rx_online_delay;
    debug_status[`LLINK_SYNC_W-1:0]   = sync_state;
  end

  ////////////////////
  // Data path
  ////////////////////

  llink_phy_unpack i_phy_unpack (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .rx_phy0         (rx_phy0),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .lanes           (lane_bus)
  );

  // One slot per channel
  for (genvar g = 0; g < `LLINK_CHAN_COUNT; g++) begin : g_slot
    llink_chan_slot i_chan_slot (
      .clk_wr       (clk_wr),
      .arst_n       (arst_n),
      .lane         (lane_bus[g]),
      .user_rx_data (user_rx[g]),
      .user_tx_data (user_tx[g])
    );
  end

  llink_phy_pack i_phy_pack (
    .clk_wr      (clk_wr),
    .arst_n      (arst_n),
    .lanes       (lane_bus),
    .mrk_userbit (tx_auto_mrk_userbit),
    .stb_userbit (tx_auto_stb_userbit),
    .tx_phy0     (tx_phy0)
  );

endmodule

/* verif/llink_clk_gen.sv */
`timescale 1ns/1ps

// Write clock and power-on reset for the testbench
module llink_clk_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_wr,
  output logic arst_n
);

  initial begin
    clk_wr = 1'b0;
    forever #(PERIOD_NS / 2) clk_wr = ~clk_wr;
  end

  // Release lands just after a rising edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_wr);
    #1 arst_n = 1'b1;
  end

endmodule

/* verif/llink_fourchan_properties.sv */
`timescale 1ns/1ps
`include "llink_config.svh"

// Protocol checks on the top level, attached with bind
module llink_fourchan_properties (
  input logic                       clk_wr,
  input logic                       arst_n,
  input llink_data_pkg::phy_word_t  tx_phy0,
  input llink_data_pkg::chan_data_t ch0_tx_data,
  input llink_data_pkg::chan_data_t ch1_tx_data,
  input llink_data_pkg::chan_data_t ch2_tx_data,
  input llink_data_pkg::chan_data_t ch3_tx_data,
  input logic                       tx_online_delay,
  input logic                       rx_online_delay
);

  // Failed assertions so far
  int                             fail_count;
  // Pad nibble of each group, group g at bits 4g+3..4g
  logic [`LLINK_CHAN_COUNT*4-1:0] pad_bits;
  logic                           tx_seen_q;

  always_comb begin
    for (int g = 0; g < `LLINK_CHAN_COUNT; g++) begin
      pad_bits[g*4 +: 4] = tx_phy0[g*`LLINK_GROUP_W + `LLINK_STB_BIT + 1 +: 4];
    end
  end

  // Sticky once tx has come up since reset
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_seen_q <= 1'b0;
    end else if (tx_online_delay) begin
      tx_seen_q <= 1'b1;
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  a_pad_zero: assert property (@(posedge clk_wr) disable iff (!arst_n)
    pad_bits == '0) else begin
    fail_count++;
    $error("tx_phy0 pad bits set");
  end

  // Rx side never up on its own
  a_rx_needs_tx: assert property (@(posedge clk_wr) disable iff (!arst_n)
    !(rx_online_delay && !tx_online_delay)) else begin
    fail_count++;
    $error("rx_online_delay high without tx_online_delay");
  end

  // Quiet outputs until the first tx bring-up
  a_quiet_until_tx: assert property (@(posedge clk_wr) disable iff (!arst_n)
    (!tx_seen_q && !tx_online_delay) |->
      (tx_phy0 == '0 &&
       (ch0_tx_data | ch1_tx_data | ch2_tx_data | ch3_tx_data) == '0)) else begin
    fail_count++;
    $error("Outputs active before tx_online_delay rose");
  end

endmodule

/* verif/llink_fourchan_tb.sv */
`timescale 1ns/1ps
`include "llink_config.svh"

module llink_fourchan_tb;

  // One table row is one clock of stimulus
  typedef struct packed {
    logic                                               tx_on;
    logic                                               rx_on;
    llink_ctrl_pkg::delay_t                             dx;
    llink_ctrl_pkg::delay_t                             dy;
    llink_data_pkg::mrk_bits_t                          mrk;
    logic                                               stb;
    llink_data_pkg::phy_word_t                          phy;
    llink_data_pkg::chan_data_t [`LLINK_CHAN_COUNT-1:0] ch;
  } stim_t;

  logic                          clk_wr;
  logic                          arst_n;
  logic                          tx_online;
  logic                          rx_online;
  llink_ctrl_pkg::delay_t        delay_x_value;
  llink_ctrl_pkg::delay_t        delay_y_value;
  llink_data_pkg::mrk_bits_t     tx_mrk_userbit;
  logic                          tx_stb_userbit;
  llink_data_pkg::phy_word_t     rx_phy0;
  llink_data_pkg::phy_word_t     tx_phy0;
  llink_data_pkg::chan_data_t    ch_rx [`LLINK_CHAN_COUNT];
  llink_data_pkg::chan_data_t    ch_tx [`LLINK_CHAN_COUNT];
  llink_ctrl_pkg::debug_status_t debug_status;

  // Stimulus rows and the expected levels after each row's edge
  stim_t stim_q [$];
  logic  exp_tx_lvl [$];
  logic  exp_rx_lvl [$];
  int    max_delay;
  logic  table_ready;

  llink_clk_gen i_clk_gen (
    .clk_wr (clk_wr),
    .arst_n (arst_n)
  );

  llink_fourchan_top i_dut (
    .clk_wr         (clk_wr),
    .arst_n         (arst_n),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .delay_x_value  (delay_x_value),
    .delay_y_value  (delay_y_value),
    .tx_mrk_userbit (tx_mrk_userbit),
    .tx_stb_userbit (tx_stb_userbit),
    .rx_phy0        (rx_phy0),
    .tx_phy0        (tx_phy0),
    .ch0_rx_data    (ch_rx[0]),
    .ch1_rx_data    (ch_rx[1]),
    .ch2_rx_data    (ch_rx[2]),
    .ch3_rx_data    (ch_rx[3]),
    .ch0_tx_data    (ch_tx[0]),
    .ch1_tx_data    (ch_tx[1]),
    .ch2_tx_data    (ch_tx[2]),
    .ch3_tx_data    (ch_tx[3]),
    .debug_status   (debug_status)
  );

  bind llink_fourchan_top llink_fourchan_properties i_props (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_phy0         (tx_phy0),
    .ch0_tx_data     (ch0_tx_data),
    .ch1_tx_data     (ch1_tx_data),
    .ch2_tx_data     (ch2_tx_data),
    .ch3_tx_data     (ch3_tx_data),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_chan(input string what, input llink_data_pkg::chan_data_t got,
                            input llink_data_pkg::chan_data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_phy(input string what, input llink_data_pkg::phy_word_t got,
                           input llink_data_pkg::phy_word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_debug(input string what, input llink_ctrl_pkg::debug_status_t got,
                             input llink_ctrl_pkg::debug_status_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  ////////////////////
  // Table and model
  ////////////////////

  function automatic llink_data_pkg::phy_word_t rand_phy();
    llink_data_pkg::phy_word_t w;
    for (int i = 0; i < `LLINK_PHY_W / 32; i++) begin
      w[i*32 +: 32] = $urandom;
    end
    return w;
  endfunction

  function automatic llink_data_pkg::chan_data_t rand_chan();
    logic [95:0] w;
    w = {$urandom, $urandom, $urandom};
    return w[`LLINK_CHAN_W-1:0];
  endfunction

  // Rows with fixed levels and delays, random data and user bits
  task automatic add_phase(input logic tx_on, input logic rx_on, input int dx,
                           input int dy, input int cycles);
    stim_t s;
    for (int c = 0; c < cycles; c++) begin
      s.tx_on = tx_on;
      s.rx_on = rx_on;
      s.dx    = llink_ctrl_pkg::delay_t'(dx);
      s.dy    = llink_ctrl_pkg::delay_t'(dy);
      s.mrk   = llink_data_pkg::mrk_bits_t'($urandom);
      s.stb   = 1'($urandom);
      s.phy   = rand_phy();
      for (int n = 0; n < `LLINK_CHAN_COUNT; n++) begin
        s.ch[n] = rand_chan();
      end
      stim_q.push_back(s);
    end
    if (dx > max_delay) max_delay = dx;
    if (dy > max_delay) max_delay = dy;
  endtask

  // Delays only change while tx is offline
  task automatic build_table();
    // tx_on, rx_on, delay_x, delay_y, cycles
    add_phase(1'b0, 1'b0, 0, 0, 4);
    add_phase(1'b1, 1'b1, 0, 0, 12);
    add_phase(1'b0, 1'b1, 3, 5, 3);
    add_phase(1'b1, 1'b0, 3, 5, 8);
    add_phase(1'b1, 1'b1, 3, 5, 20);
    // Rx drop with tx still up
    add_phase(1'b1, 1'b0, 3, 5, 5);
    add_phase(1'b1, 1'b1, 3, 5, 15);
    add_phase(1'b0, 1'b0, 12, 1, 4);
    add_phase(1'b1, 1'b1, 12, 1, 25);
    // Tx drop clears both directions
    add_phase(1'b0, 1'b1, 12, 1, 4);
  endtask

  // Tx level once tx has been sampled high dx+2 edges in a row,
  // rx level once rx and tx level have both been high dy+2 edges in a row
  task automatic model_levels();
    int   tx_run;
    int   rx_run;
    logic tx_lvl;
    logic rx_lvl;
    tx_run = 0;
    rx_run = 0;
    tx_lvl = 1'b0;
    foreach (stim_q[k]) begin
      // Rx run looks at the tx level from before this edge
      rx_run = (stim_q[k].tx_on && stim_q[k].rx_on && tx_lvl) ? rx_run + 1 : 0;
      tx_run = stim_q[k].tx_on ? tx_run + 1 : 0;
      tx_lvl = (tx_run >= int'(stim_q[k].dx) + 2);
      rx_lvl = tx_lvl && (rx_run >= int'(stim_q[k].dy) + 2);
      exp_tx_lvl.push_back(tx_lvl);
      exp_rx_lvl.push_back(rx_lvl);
    end
  endtask

  function automatic llink_ctrl_pkg::debug_status_t exp_debug(input int k);
    llink_ctrl_pkg::debug_status_t d;
    llink_ctrl_pkg::sync_state_t   st;
    if (exp_rx_lvl[k]) st = llink_ctrl_pkg::SYNC_UP;
    else if (exp_tx_lvl[k]) st = llink_ctrl_pkg::SYNC_RX_WAIT;
    else if (stim_q[k].tx_on) st = llink_ctrl_pkg::SYNC_TX_WAIT;
    else st = llink_ctrl_pkg::SYNC_OFF;
    d = '0;
    d[`LLINK_DBG_TX_BIT]   = exp_tx_lvl[k];
    d[`LLINK_DBG_RX_BIT]   = exp_rx_lvl[k];
    d[`LLINK_SYNC_W-1:0]   = st;
    return d;
  endfunction

  // Group g holds data at 0, marker at 74, strobe at 75 in group 0 only
  function automatic llink_data_pkg::phy_word_t build_phy(
      input llink_data_pkg::chan_data_t [`LLINK_CHAN_COUNT-1:0] fields,
      input llink_data_pkg::mrk_bits_t mrk, input logic stb);
    llink_data_pkg::phy_word_t w;
    w = '0;
    for (int g = 0; g < `LLINK_CHAN_COUNT; g++) begin
      w[g*`LLINK_GROUP_W +: `LLINK_CHAN_W]     = fields[g];
      w[g*`LLINK_GROUP_W + `LLINK_MRK_BIT]     = mrk[g];
    end
    w[`LLINK_STB_BIT] = stb;
    return w;
  endfunction

  task automatic apply_row(input stim_t s);
    tx_online      = s.tx_on;
    rx_online      = s.rx_on;
    delay_x_value  = s.dx;
    delay_y_value  = s.dy;
    tx_mrk_userbit = s.mrk;
    tx_stb_userbit = s.stb;
    rx_phy0        = s.phy;
    for (int n = 0; n < `LLINK_CHAN_COUNT; n++) begin
      ch_rx[n] = s.ch[n];
    end
  endtask

  // Outputs right after the edge that sampled row k
  task automatic check_step(input int k);
    llink_data_pkg::chan_data_t [`LLINK_CHAN_COUNT-1:0] fields;
    llink_data_pkg::chan_data_t                         exp_ch;
    llink_data_pkg::phy_word_t                          prev_phy;
    llink_data_pkg::mrk_bits_t                          mrk;
    logic                                               stb;
    prev_phy = (k > 0) ? stim_q[k-1].phy : '0;
    for (int n = 0; n < `LLINK_CHAN_COUNT; n++) begin
      // Rx path takes PHY row k-1 through unpack then slot
      exp_ch = '0;
      if (k > 0 && exp_rx_lvl[k-1]) exp_ch = prev_phy[n*`LLINK_GROUP_W +: `LLINK_CHAN_W];
      check_chan($sformatf("ch%0d_tx_data", n), ch_tx[n], exp_ch);
      // Tx field loaded from row k-1 under the tx level one edge earlier
      fields[n] = '0;
      if (k > 1 && exp_tx_lvl[k-2]) fields[n] = stim_q[k-1].ch[n];
    end
    // User bits only see the pack register
    mrk = '0;
    stb = 1'b0;
    if (k > 0 && exp_tx_lvl[k-1]) begin
      mrk = stim_q[k].mrk;
      stb = stim_q[k].stb;
    end
    check_phy("tx_phy0", tx_phy0, build_phy(fields, mrk, stb));
    check_debug("debug_status", debug_status, exp_debug(k));
    if (i_dut.i_props.fail_count != 0) begin
      abort_run("A bound assertion on the DUT top level failed");
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int n_rows;
    void'($urandom(27752));
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    delay_x_value  = '0;
    delay_y_value  = '0;
    tx_mrk_userbit = '0;
    tx_stb_userbit = 1'b0;
    rx_phy0        = '0;
    for (int n = 0; n < `LLINK_CHAN_COUNT; n++) begin
      ch_rx[n] = '0;
    end
    max_delay   = 0;
    table_ready = 1'b0;
    build_table();
    model_levels();
    n_rows      = stim_q.size();
    table_ready = 1'b1;

    // Straight out of reset everything reads zero
    wait (arst_n === 1'b1);
    for (int n = 0; n < `LLINK_CHAN_COUNT; n++) begin
      check_chan($sformatf("ch%0d_tx_data", n), ch_tx[n], '0);
    end
    check_phy("tx_phy0", tx_phy0, '0);
    check_debug("debug_status", debug_status, '0);

    // Drive row k and check it one edge later
    for (int k = 0; k <= n_rows; k++) begin
      @(posedge clk_wr);
      #1;
      if (k > 0) check_step(k - 1);
      if (k < n_rows) apply_row(stim_q[k]);
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

  // Watchdog sized from the table and its longest delay
  initial begin
    int limit;
    wait (table_ready === 1'b1);
    limit = stim_q.size() * (max_delay + 1) + 50;
    repeat (limit) @(posedge clk_wr);
    abort_run($sformatf("Watchdog expired after %0d cycles, test did not finish", limit));
  end

endmodule

/* flist.f */
+incdir+logic
logic/llink_data_pkg.sv
logic/llink_ctrl_pkg.sv
logic/llink_lane_if.sv
logic/llink_auto_sync.sv
logic/llink_phy_unpack.sv
logic/llink_chan_slot.sv
logic/llink_phy_pack.sv
logic/llink_fourchan_top.sv
verif/llink_clk_gen.sv
verif/llink_fourchan_properties.sv
verif/llink_fourchan_tb.sv

/* Makefile */
SIM = obj_dir/llink_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f flist.f \
		--top-module llink_fourchan_tb -o llink_sim

run: compile
	out=$$(./$(SIM) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
